// ==== source/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    // major opcodes of the supported classes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // how execute treats a decoded entry
    typedef enum logic [1:0] {
        kind_alu,
        kind_branch,
        kind_jump,
        kind_none
    } instr_kind_t;

    // one instruction word, seen through the format its opcode calls for
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [reg_addr_w-1:0] rs2;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } r_view;
        struct packed {
            logic [11:0]           imm12;
            logic [reg_addr_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } i_view;
        struct packed {
            logic [19:0]           imm20;
            logic [reg_addr_w-1:0] rd;
            logic [6:0]            opcode;
        } u_view;
    } inst_word_t;

endpackage

`default_nettype wire

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter logic [core_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       inst_valid,
    input  wire  [core_pkg::xlen-1:0] inst,
    input  wire                       fd_ready,
    input  wire                       redirect,
    input  wire  [core_pkg::xlen-1:0] redirect_pc,
    output logic [core_pkg::xlen-1:0] fetch_pc,
    output logic                      inst_ready,
    output logic                      fd_valid,
    output logic [core_pkg::xlen-1:0] fd_pc,
    output logic [core_pkg::xlen-1:0] fd_inst
);

    logic run;   // first fetch waits one cycle after reset
    logic fire;

    // take a word when the fetch/decode register is free or draining
    assign inst_ready = run && !redirect && (!fd_valid || fd_ready);
    assign fire = inst_valid && inst_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            run      <= 1'b0;
            fetch_pc <= reset_pc;
            fd_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (redirect) begin
                fetch_pc <= redirect_pc;
                fd_valid <= 1'b0;   // wrong path entry
            end else if (fire) begin
                fetch_pc <= fetch_pc + 32'd4;
                fd_valid <= 1'b1;
            end else if (fd_ready) begin
                fd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            fd_pc   <= fetch_pc;
            fd_inst <= inst;
        end
    end

    // a redirect blocks fetch and lands the target with an empty register
    a_redirect: assert property (@(posedge clk) disable iff (reset)
        redirect |-> !inst_ready ##1 (fetch_pc == $past(redirect_pc) && !fd_valid));

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             fd_valid,
    input  wire  [core_pkg::xlen-1:0]       fd_pc,
    input  wire  [core_pkg::xlen-1:0]       fd_inst,
    input  wire                             de_ready,
    input  wire                             redirect,
    input  wire                             pend_valid,
    input  wire  [core_pkg::reg_addr_w-1:0] pend_rd,
    input  wire  [core_pkg::xlen-1:0]       rs1_data,
    input  wire  [core_pkg::xlen-1:0]       rs2_data,
    output logic                            fd_ready,
    output logic [core_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [core_pkg::reg_addr_w-1:0] rs2_addr,
    output logic                            de_valid,
    output logic [core_pkg::xlen-1:0]       de_pc,
    output core_pkg::instr_kind_t           de_kind,
    output core_pkg::alu_op_t               de_alu_op,
    output logic [core_pkg::xlen-1:0]       de_op_a,
    output logic [core_pkg::xlen-1:0]       de_op_b,
    output logic [core_pkg::xlen-1:0]       de_src1,
    output logic [core_pkg::xlen-1:0]       de_src2,
    output logic [2:0]                      de_funct3,
    output logic [core_pkg::xlen-1:0]       de_target,
    output logic [core_pkg::reg_addr_w-1:0] de_rd,
    output logic                            de_we
);

    core_pkg::inst_word_t      iw;
    logic [6:0]                opcode;
    logic [6:0]                funct7;
    logic [core_pkg::xlen-1:0] imm_i, imm_b, imm_u, imm_j;
    core_pkg::instr_kind_t     kind;
    core_pkg::alu_op_t         alu_op;
    logic [core_pkg::xlen-1:0] op_a, op_b, target;
    logic                      we, use_rs1, use_rs2;
    logic                      hit1, hit2, stall, load;

    assign iw       = fd_inst;
    assign opcode   = iw.r_view.opcode;
    assign funct7   = iw.r_view.funct7;
    assign rs1_addr = iw.r_view.rs1;
    assign rs2_addr = iw.r_view.rs2;

    assign imm_i = {{20{iw.i_view.imm12[11]}}, iw.i_view.imm12};
    assign imm_u = {iw.u_view.imm20, 12'b0};
    // B scatters its bits over the funct7 and rd fields
    assign imm_b = {{20{funct7[6]}}, iw.r_view.rd[0], funct7[5:0], iw.r_view.rd[4:1], 1'b0};
    assign imm_j = {{12{iw.u_view.imm20[19]}}, iw.u_view.imm20[7:0], iw.u_view.imm20[8],
                    iw.u_view.imm20[18:9], 1'b0};

    always_comb begin
        kind    = core_pkg::kind_none;   // unsupported retires with no write
        we      = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        op_a    = rs1_data;
        op_b    = imm_i;
        target  = fd_pc + imm_b;
        case (opcode)
            core_pkg::op_reg: begin
                kind    = core_pkg::kind_alu;
                we      = 1'b1;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                op_b    = rs2_data;
            end
            core_pkg::op_imm: begin
                kind    = core_pkg::kind_alu;
                we      = 1'b1;
                use_rs1 = 1'b1;
            end
            core_pkg::op_lui: begin
                kind = core_pkg::kind_alu;
                we   = 1'b1;
                op_a = '0;
                op_b = imm_u;
            end
            core_pkg::op_auipc: begin
                kind = core_pkg::kind_alu;
                we   = 1'b1;
                op_a = fd_pc;
                op_b = imm_u;
            end
            core_pkg::op_jal: begin
                kind   = core_pkg::kind_jump;
                we     = 1'b1;
                target = fd_pc + imm_j;
            end
            core_pkg::op_jalr: begin
                kind    = core_pkg::kind_jump;
                we      = 1'b1;
                use_rs1 = 1'b1;
                target  = (rs1_data + imm_i) & ~32'd1;
            end
            core_pkg::op_branch: begin
                kind    = core_pkg::kind_branch;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        alu_op = core_pkg::alu_add;   // lui, auipc and addi
        if (opcode == core_pkg::op_reg || opcode == core_pkg::op_imm) begin
            case (iw.r_view.funct3)
                3'b000: begin
                    if (opcode == core_pkg::op_reg && funct7[5])
                        alu_op = core_pkg::alu_sub;
                end
                3'b001: alu_op = core_pkg::alu_sll;
                3'b010: alu_op = core_pkg::alu_slt;
                3'b011: alu_op = core_pkg::alu_sltu;
                3'b100: alu_op = core_pkg::alu_xor;
                3'b101: alu_op = funct7[5] ? core_pkg::alu_sra : core_pkg::alu_srl;
                3'b110: alu_op = core_pkg::alu_or;
                default: alu_op = core_pkg::alu_and;
            endcase
        end
    end

    // read after write against the de entry and the waiting retire record
    assign hit1 = use_rs1 && rs1_addr != '0 &&
                  ((de_valid && de_we && de_rd == rs1_addr) || (pend_valid && pend_rd == rs1_addr));
    assign hit2 = use_rs2 && rs2_addr != '0 &&
                  ((de_valid && de_we && de_rd == rs2_addr) || (pend_valid && pend_rd == rs2_addr));
    assign stall = hit1 || hit2;

    assign fd_ready = !stall && !redirect && (!de_valid || de_ready);
    assign load = fd_valid && fd_ready;

    always_ff @(posedge clk) begin
        if (reset)
            de_valid <= 1'b0;
        else if (load)
            de_valid <= 1'b1;
        else if (de_ready)
            de_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            de_pc     <= fd_pc;
            de_kind   <= kind;
            de_alu_op <= alu_op;
            de_op_a   <= op_a;
            de_op_b   <= op_b;
            de_src1   <= rs1_data;
            de_src2   <= rs2_data;
            de_funct3 <= iw.r_view.funct3;
            de_target <= target;
            de_rd     <= iw.r_view.rd;
            de_we     <= we;
        end
    end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                             clk,
    input  wire  [core_pkg::reg_addr_w-1:0] rs1_addr,
    input  wire  [core_pkg::reg_addr_w-1:0] rs2_addr,
    input  wire                             rf_we,
    input  wire  [core_pkg::reg_addr_w-1:0] rf_waddr,
    input  wire  [core_pkg::xlen-1:0]       rf_wdata,
    output logic [core_pkg::xlen-1:0]       rs1_data,
    output logic [core_pkg::xlen-1:0]       rs2_data
);

    logic [core_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rf_we)
            regs[rf_waddr] <= rf_wdata;
    end

    // x0 is never stored, so mask it on read
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // execute filters x0 writes before they get here
    a_no_x0: assert property (@(posedge clk) rf_we |-> rf_waddr != '0);

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             de_valid,
    input  wire  [core_pkg::xlen-1:0]       de_pc,
    input  core_pkg::instr_kind_t           de_kind,
    input  core_pkg::alu_op_t               de_alu_op,
    input  wire  [core_pkg::xlen-1:0]       de_op_a,
    input  wire  [core_pkg::xlen-1:0]       de_op_b,
    input  wire  [core_pkg::xlen-1:0]       de_src1,
    input  wire  [core_pkg::xlen-1:0]       de_src2,
    input  wire  [2:0]                      de_funct3,
    input  wire  [core_pkg::xlen-1:0]       de_target,
    input  wire  [core_pkg::reg_addr_w-1:0] de_rd,
    input  wire                             de_we,
    input  wire                             retire_ready,
    output logic                            de_ready,
    output logic                            redirect,
    output logic [core_pkg::xlen-1:0]       redirect_pc,
    output logic                            pend_valid,
    output logic [core_pkg::reg_addr_w-1:0] pend_rd,
    output logic                            rf_we,
    output logic [core_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [core_pkg::xlen-1:0]       rf_wdata,
    output logic                            retire_valid,
    output logic [core_pkg::xlen-1:0]       retire_pc,
    output logic [core_pkg::reg_addr_w-1:0] retire_rd,
    output logic [core_pkg::xlen-1:0]       retire_data,
    output logic                            retire_we
);

    logic [core_pkg::xlen-1:0] alu_res;
    logic                      taken;
    logic                      accept;

    always_comb begin
        case (de_alu_op)
            core_pkg::alu_sub:  alu_res = de_op_a - de_op_b;
            core_pkg::alu_sll:  alu_res = de_op_a << de_op_b[4:0];
            core_pkg::alu_slt:  alu_res = {31'b0, $signed(de_op_a) < $signed(de_op_b)};
            core_pkg::alu_sltu: alu_res = {31'b0, de_op_a < de_op_b};
            core_pkg::alu_xor:  alu_res = de_op_a ^ de_op_b;
            core_pkg::alu_srl:  alu_res = de_op_a >> de_op_b[4:0];
            core_pkg::alu_sra:  alu_res = $unsigned($signed(de_op_a) >>> de_op_b[4:0]);
            core_pkg::alu_or:   alu_res = de_op_a | de_op_b;
            core_pkg::alu_and:  alu_res = de_op_a & de_op_b;
            default:            alu_res = de_op_a + de_op_b;
        endcase
    end

    always_comb begin
        case (de_funct3)
            3'b000:  taken = de_src1 == de_src2;
            3'b001:  taken = de_src1 != de_src2;
            3'b100:  taken = $signed(de_src1) < $signed(de_src2);
            3'b101:  taken = $signed(de_src1) >= $signed(de_src2);
            3'b110:  taken = de_src1 < de_src2;
            3'b111:  taken = de_src1 >= de_src2;
            default: taken = 1'b0;   // reserved funct3 falls through
        endcase
    end

    assign de_ready = !retire_valid || retire_ready;
    assign accept = de_valid && de_ready;

    assign redirect = accept && (de_kind == core_pkg::kind_jump ||
                                 (de_kind == core_pkg::kind_branch && taken));
    assign redirect_pc = de_target;

    always_ff @(posedge clk) begin
        if (reset)
            retire_valid <= 1'b0;
        else if (accept)
            retire_valid <= 1'b1;
        else if (retire_ready)
            retire_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            retire_pc   <= de_pc;
            retire_rd   <= de_rd;
            retire_we   <= de_we;
            retire_data <= (de_kind == core_pkg::kind_jump) ? de_pc + 32'd4 : alu_res;   // link
        end
    end

    assign pend_valid = retire_valid && retire_we && retire_rd != '0;
    assign pend_rd    = retire_rd;

    // register write happens at handoff
    assign rf_we    = pend_valid && retire_ready;
    assign rf_waddr = retire_rd;
    assign rf_wdata = retire_data;

    a_hold: assert property (@(posedge clk) disable iff (reset)
        retire_valid && !retire_ready |=> retire_valid &&
            $stable({retire_pc, retire_rd, retire_data, retire_we}));

endmodule

`default_nettype wire

// ==== source/riscv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_core #(
    parameter logic [core_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  wire                             clk,
    input  wire                             reset,
    input  wire                             inst_valid,
    input  wire  [core_pkg::xlen-1:0]       inst,
    input  wire                             retire_ready,
    output logic [core_pkg::xlen-1:0]       fetch_pc,
    output logic                            inst_ready,
    output logic                            retire_valid,
    output logic [core_pkg::xlen-1:0]       retire_pc,
    output logic [core_pkg::reg_addr_w-1:0] retire_rd,
    output logic [core_pkg::xlen-1:0]       retire_data,
    output logic                            retire_we
);

    // fetch to decode
    logic                            fd_valid, fd_ready;
    logic [core_pkg::xlen-1:0]       fd_pc, fd_inst;

    // decode to execute
    logic                            de_valid, de_ready, de_we;
    logic [core_pkg::xlen-1:0]       de_pc, de_op_a, de_op_b, de_src1, de_src2, de_target;
    core_pkg::instr_kind_t           de_kind;
    core_pkg::alu_op_t               de_alu_op;
    logic [2:0]                      de_funct3;
    logic [core_pkg::reg_addr_w-1:0] de_rd;

    logic                            redirect;
    logic [core_pkg::xlen-1:0]       redirect_pc;
    logic                            pend_valid;
    logic [core_pkg::reg_addr_w-1:0] pend_rd;

    // register file ports
    logic [core_pkg::reg_addr_w-1:0] rs1_addr, rs2_addr, rf_waddr;
    logic [core_pkg::xlen-1:0]       rs1_data, rs2_data, rf_wdata;
    logic                            rf_we;

    fetch_stage #(
        .reset_pc(reset_pc)
    ) fetch_stage_i (
        .clk(clk), .reset(reset),
        .inst_valid(inst_valid), .inst(inst),
        .fd_ready(fd_ready), .redirect(redirect), .redirect_pc(redirect_pc),
        .fetch_pc(fetch_pc), .inst_ready(inst_ready),
        .fd_valid(fd_valid), .fd_pc(fd_pc), .fd_inst(fd_inst)
    );

    decode_stage decode_stage_i (
        .clk(clk), .reset(reset),
        .fd_valid(fd_valid), .fd_pc(fd_pc), .fd_inst(fd_inst),
        .de_ready(de_ready), .redirect(redirect),
        .pend_valid(pend_valid), .pend_rd(pend_rd),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .fd_ready(fd_ready), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .de_valid(de_valid), .de_pc(de_pc), .de_kind(de_kind), .de_alu_op(de_alu_op),
        .de_op_a(de_op_a), .de_op_b(de_op_b), .de_src1(de_src1), .de_src2(de_src2),
        .de_funct3(de_funct3), .de_target(de_target), .de_rd(de_rd), .de_we(de_we)
    );

    reg_file reg_file_i (
        .clk(clk),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    execute_stage execute_stage_i (
        .clk(clk), .reset(reset),
        .de_valid(de_valid), .de_pc(de_pc), .de_kind(de_kind), .de_alu_op(de_alu_op),
        .de_op_a(de_op_a), .de_op_b(de_op_b), .de_src1(de_src1), .de_src2(de_src2),
        .de_funct3(de_funct3), .de_target(de_target), .de_rd(de_rd), .de_we(de_we),
        .retire_ready(retire_ready),
        .de_ready(de_ready), .redirect(redirect), .redirect_pc(redirect_pc),
        .pend_valid(pend_valid), .pend_rd(pend_rd),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_data(retire_data), .retire_we(retire_we)
    );

endmodule

`default_nettype wire

// ==== bench/rv_asm.svh ====
`ifndef rv_asm_svh
`define rv_asm_svh

// encoders take their fields in assembly order
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, core_pkg::op_reg};
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
                                      input logic [19:0] imm);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], core_pkg::op_branch};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, core_pkg::op_jal};
endfunction

logic [31:0] mregs [32];   // architectural state of the model

// one instruction of the ISA, in program order
task automatic model_step(input logic [31:0] pc, input logic [31:0] w,
                          output logic [31:0] npc, output logic [4:0] rd,
                          output logic [31:0] data, output logic we);
    logic [31:0] a, b, c, imm_i, imm_b, imm_j;
    logic [2:0]  f3;
    logic        alt, take;
    f3    = w[14:12];
    rd    = w[11:7];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    a     = mregs[w[19:15]];
    c     = mregs[w[24:20]];
    b     = (w[6:0] == core_pkg::op_reg) ? c : imm_i;
    alt   = w[30] && (w[6:0] == core_pkg::op_reg || f3 == 3'b101);   // sub or sra
    npc   = pc + 32'd4;
    data  = '0;
    we    = 1'b0;
    take  = 1'b0;
    case (w[6:0])
        core_pkg::op_reg, core_pkg::op_imm: begin
            we = 1'b1;
            case (f3)
                3'b000: data = alt ? a - b : a + b;
                3'b001: data = a << b[4:0];
                3'b010: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011: data = (a < b) ? 32'd1 : 32'd0;
                3'b100: data = a ^ b;
                3'b101: data = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'b110: data = a | b;
                default: data = a & b;
            endcase
        end
        core_pkg::op_lui: begin
            we   = 1'b1;
            data = {w[31:12], 12'b0};
        end
        core_pkg::op_auipc: begin
            we   = 1'b1;
            data = pc + {w[31:12], 12'b0};
        end
        core_pkg::op_jal: begin
            we   = 1'b1;
            data = pc + 32'd4;
            npc  = pc + imm_j;
        end
        core_pkg::op_jalr: begin
            we   = 1'b1;
            data = pc + 32'd4;
            npc  = (a + imm_i) & ~32'd1;
        end
        core_pkg::op_branch: begin
            case (f3)
                3'b000: take = a == c;
                3'b001: take = a != c;
                3'b100: take = $signed(a) < $signed(c);
                3'b101: take = $signed(a) >= $signed(c);
                3'b110: take = a < c;
                3'b111: take = a >= c;
                default: take = 1'b0;
            endcase
            if (take)
                npc = pc + imm_b;
        end
        default: ;   // anything else retires with no write
    endcase
    if (we && rd != 5'd0)
        mregs[rd] = data;
endtask

`endif

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam logic [31:0] reset_pc = 32'h8000_0000;
    localparam int reset_cycles = 16;
    localparam logic [31:0] halt_word = 32'h0000_006f;   // jal x0, 0
    localparam logic [31:0] poison = 32'hbad0_0f93;      // addi x31, x0, 0xbad

    logic        clk, reset, inst_valid, retire_ready;
    logic [31:0] inst, fetch_pc, retire_pc, retire_data;
    logic        inst_ready, retire_valid, retire_we;
    logic [4:0]  retire_rd;

    logic [31:0] prog [256];
    int          prog_len;
    logic [69:0] exp_q [$];   // pc, rd, data, we
    logic [31:0] lfsr, first_pc;
    logic        rand_valid, rand_ready, was_held;
    logic [69:0] held_rec;
    int          errors, checks, tests, test_retired, cycles, cycle_limit;

    `include "rv_asm.svh"

    riscv_core #(
        .reset_pc(reset_pc)
    ) riscv_core_i (
        .clk(clk), .reset(reset),
        .inst_valid(inst_valid), .inst(inst), .retire_ready(retire_ready),
        .fetch_pc(fetch_pc), .inst_ready(inst_ready),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_data(retire_data), .retire_we(retire_we)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory answers the current fetch address
    assign inst = prog[fetch_pc[9:2]];

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    always @(posedge clk) begin : drive_handshake
        logic gap;
        logic hold;
        gap = 1'b0;
        hold = 1'b0;
        if (rand_valid) begin
            gap = lfsr_bit();
            gap = gap & lfsr_bit();   // about one cycle in four
        end
        if (rand_ready)
            hold = lfsr_bit();
        inst_valid <= !gap;
        retire_ready <= !hold;
    end

    always @(posedge clk) begin : watch_retire
        logic [69:0] rec;
        logic [69:0] e;
        rec = {retire_pc, retire_rd, retire_data, retire_we};
        if (reset) begin
            was_held <= 1'b0;
        end else begin
            if (was_held) begin
                assert (retire_valid) else begin
                    $display("retire_valid dropped before the record was accepted");
                    errors++;
                end
                assert (rec === held_rec) else begin
                    $display("[ERROR] retire record expected %h got %h", held_rec, rec);
                    errors++;
                end
            end
            was_held <= retire_valid && !retire_ready;
            held_rec <= rec;
            if (retire_valid && retire_ready && exp_q.size() != 0) begin
                e = exp_q.pop_front();
                if (test_retired == 0)
                    first_pc = retire_pc;
                test_retired++;
                check_value("retire_pc", e[69:38], retire_pc);
                check_value("retire_we", e[0], retire_we);
                if (e[0]) begin
                    check_value("retire_rd", e[37:33], retire_rd);
                    check_value("retire_data", e[32:1], retire_data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: retire stream stopped after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic start_program();
        for (int i = 0; i < 256; i++)
            prog[i] = (reset_pc + 4 * i) ^ 32'h3c3c_5a5a;   // never executed
        prog_len = 0;
    endtask

    task automatic put(input logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic model_run();
        logic [31:0] pc, w, npc, data;
        logic [4:0]  rd;
        logic        we;
        int          n;
        pc = reset_pc;
        exp_q.delete();
        for (n = 0; n < 1000; n++) begin
            w = prog[pc[9:2]];
            model_step(pc, w, npc, rd, data, we);
            exp_q.push_back({pc, rd, data, we});
            if (w == halt_word)
                break;
            pc = npc;
        end
    endtask

    task automatic run_program(input string name, input logic rand_mode);
        int err0;
        err0 = errors;
        @(posedge clk);
        reset <= 1'b1;
        rand_valid <= 1'b0;
        rand_ready <= 1'b0;
        @(posedge clk);
        model_run();
        cycle_limit = cycle_limit + reset_cycles + 4 + exp_q.size() * 20;
        repeat (reset_cycles - 1) @(posedge clk);
        check_value("retire_valid", 0, retire_valid);
        check_value("fetch_pc", reset_pc, fetch_pc);
        test_retired = 0;
        reset <= 1'b0;
        rand_valid <= rand_mode;
        rand_ready <= rand_mode;
        @(posedge clk);
        check_value("inst_ready", 0, inst_ready);   // first cycle out of reset
        @(posedge clk);
        check_value("inst_ready", 1, inst_ready);
        while (exp_q.size() != 0)
            @(posedge clk);
        check_value("retire_pc", reset_pc, first_pc);
        tests++;
        $display("test %s: %0d retired, %0d errors", name, test_retired, errors - err0);
    endtask

    task automatic build_alu_mix();
        put(enc_i(core_pkg::op_imm, 3'b000, 1, 0, 12'hff9));   // x1 = -7
        put(enc_i(core_pkg::op_imm, 3'b000, 2, 0, 12'h005));
        put(enc_u(core_pkg::op_lui, 3, 20'h80000));
        put(enc_r(7'h00, 3'b000, 4, 1, 2));
        put(enc_r(7'h20, 3'b000, 5, 1, 2));
        put(enc_r(7'h00, 3'b001, 6, 2, 2));
        put(enc_r(7'h00, 3'b010, 7, 1, 2));   // signed -7 < 5
        put(enc_r(7'h00, 3'b011, 8, 1, 2));   // unsigned not less
        put(enc_r(7'h00, 3'b100, 9, 1, 2));
        put(enc_r(7'h00, 3'b101, 10, 3, 2));
        put(enc_r(7'h20, 3'b101, 11, 3, 2));
        put(enc_r(7'h00, 3'b110, 12, 1, 2));
        put(enc_r(7'h00, 3'b111, 13, 1, 2));
        put(enc_i(core_pkg::op_imm, 3'b000, 14, 1, 12'h064));
        put(enc_i(core_pkg::op_imm, 3'b000, 26, 2, 12'h400));   // bit 30 set but still add
        put(enc_i(core_pkg::op_imm, 3'b010, 15, 1, 12'hfff));
        put(enc_i(core_pkg::op_imm, 3'b011, 16, 2, 12'hfff));
        put(enc_i(core_pkg::op_imm, 3'b100, 17, 1, 12'h555));
        put(enc_i(core_pkg::op_imm, 3'b110, 18, 2, 12'h700));
        put(enc_i(core_pkg::op_imm, 3'b111, 19, 1, 12'h0f0));
        put(enc_i(core_pkg::op_imm, 3'b001, 20, 2, 12'h01f));
        put(enc_i(core_pkg::op_imm, 3'b101, 21, 3, 12'h004));
        put(enc_i(core_pkg::op_imm, 3'b101, 22, 3, 12'h404));   // srai
        put(enc_u(core_pkg::op_auipc, 23, 20'h00001));
        put(enc_i(core_pkg::op_imm, 3'b000, 0, 2, 12'h009));    // x0 stays zero
        put(enc_r(7'h00, 3'b000, 24, 0, 2));
        put(32'h0000_500b);   // custom-0 with no write
    endtask

    task automatic build_dep_chain();
        put(enc_i(core_pkg::op_imm, 3'b000, 1, 0, 12'h001));
        put(enc_r(7'h00, 3'b000, 1, 1, 1));
        put(enc_i(core_pkg::op_imm, 3'b000, 2, 1, 12'h003));
        put(enc_i(core_pkg::op_imm, 3'b001, 3, 2, 12'h002));
        put(enc_r(7'h20, 3'b000, 4, 3, 1));
        put(enc_r(7'h00, 3'b100, 5, 4, 3));
        put(enc_r(7'h00, 3'b000, 6, 5, 4));
        put(enc_i(core_pkg::op_imm, 3'b000, 7, 6, 12'h001));
        put(enc_i(core_pkg::op_imm, 3'b000, 7, 7, 12'h001));
        put(enc_i(core_pkg::op_imm, 3'b000, 7, 7, 12'hfff));
        put(enc_r(7'h00, 3'b000, 8, 7, 7));
        put(enc_r(7'h20, 3'b101, 9, 8, 1));
        put(enc_u(core_pkg::op_lui, 10, 20'habcde));
        put(enc_i(core_pkg::op_imm, 3'b000, 10, 10, 12'h123));
    endtask

    // taken one skips the poison word while the not-taken one falls into the counter
    task automatic branch_pair(input logic [2:0] f3, input logic [4:0] t1, input logic [4:0] t2,
                               input logic [4:0] n1, input logic [4:0] n2);
        put(enc_b(f3, t1, t2, 13'd8));
        put(poison);
        put(enc_b(f3, n1, n2, 13'd8));
        put(enc_i(core_pkg::op_imm, 3'b000, 10, 10, 12'h001));
    endtask

    task automatic build_branches();
        put(enc_i(core_pkg::op_imm, 3'b000, 1, 0, 12'h005));
        put(enc_i(core_pkg::op_imm, 3'b000, 2, 0, 12'hffd));    // x2 = -3
        put(enc_i(core_pkg::op_imm, 3'b000, 3, 0, 12'h005));
        put(enc_i(core_pkg::op_imm, 3'b000, 10, 0, 12'h000));
        branch_pair(3'b000, 1, 3, 1, 2);
        branch_pair(3'b001, 1, 2, 1, 3);
        branch_pair(3'b100, 2, 1, 1, 2);
        branch_pair(3'b101, 1, 2, 2, 1);
        branch_pair(3'b110, 1, 2, 2, 1);
        branch_pair(3'b111, 2, 1, 1, 2);
        put(enc_j(11, 21'd12));
        put(poison);
        put(poison);
        put(enc_u(core_pkg::op_auipc, 13, 20'h00000));
        put(enc_i(core_pkg::op_jalr, 3'b000, 12, 13, 12'h011));   // odd offset loses bit 0
        put(poison);
        put(poison);
        put(enc_r(7'h00, 3'b000, 14, 11, 12));
        put(enc_i(core_pkg::op_imm, 3'b000, 15, 0, 12'h003));
        put(enc_i(core_pkg::op_imm, 3'b000, 15, 15, 12'hfff));
        put(enc_b(3'b001, 15, 0, 13'h1ffc));   // back to the decrement
    endtask

    initial begin
        reset = 1'b1;
        inst_valid = 1'b0;
        retire_ready = 1'b0;
        rand_valid = 1'b0;
        rand_ready = 1'b0;
        was_held = 1'b0;
        lfsr = 32'h3a8d_bc99;
        errors = 0;
        checks = 0;
        tests = 0;
        cycles = 0;
        cycle_limit = reset_cycles;
        for (int i = 0; i < 32; i++)
            mregs[i] = '0;

        start_program();
        put(enc_i(core_pkg::op_imm, 3'b000, 1, 0, 12'h123));
        put(enc_i(core_pkg::op_imm, 3'b000, 2, 1, 12'hfff));
        put(enc_u(core_pkg::op_lui, 3, 20'h12345));
        put(halt_word);
        run_program("reset", 1'b0);

        start_program();
        build_alu_mix();
        put(halt_word);
        run_program("alu_mix", 1'b0);

        start_program();
        build_dep_chain();
        put(halt_word);
        run_program("dependent", 1'b0);

        start_program();
        build_branches();
        put(halt_word);
        run_program("branches", 1'b0);

        start_program();
        build_alu_mix();
        build_branches();
        build_dep_chain();
        put(halt_word);
        run_program("backpressure", 1'b1);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+bench
source/core_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/riscv_core.sv
bench/core_tb.sv
